// File: Makefile
# Verilator build and run for the writeback testbench

VERILATOR ?= verilator
TOP       ?= tb_wb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# the log decides pass or fail, a crash also fails through its exit status
run: compile
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/tb_wb.sv
// writeback testbench
`timescale 1ns/100ps

module tb_wb
  import wb_pkg::*;
();

  localparam int ADDR_W = 3;
  // CF PF AF ZF SF DF OF
  localparam logic [31:0] defined_flags = 32'h0000_0cd5;
  // DF and ZF of new_flags come from the row and the rest is random
  localparam logic [31:0] steered_flags = 32'h0000_0440;

  typedef struct {
    string       name;
    logic [5:0]  req;  // v ld1 ld2 ld3 store flags
    logic [2:0]  str;  // cmps first, cmps second, repne first
    logic [1:0]  ds;
    logic [8:0]  drs;
    logic [5:0]  rds;
    logic [31:0] ptr, cnt, aff, nf, alu, addr;
    logic        e_we, e_done;
    logic [31:0] e_data, e_rd_a, e_rd_b, e_flags;
  } row_t;

  logic clk, rst, wb_v;
  logic ld_gpr1, ld_gpr2, ld_gpr3, dcache_write, ld_flags;
  logic [31:0] flags_affected, new_flags;
  logic is_cmps_first, is_cmps_second, is_repne_first;
  logic [1:0] datasize, dcache_size;
  logic [31:0] alu_result, cmps_pointer, count, address;
  logic [ADDR_W-1:0] dr1, dr2, dr3, rd_addr_a, rd_addr_b;
  logic [31:0] rd_data_a, rd_data_b, flags, dcache_data, dcache_addr;
  logic dcache_we, repne_done;

  row_t rows[$];
  logic [31:0] lcg_state = 32'h18d5d614;
  int errors = 0;
  int checks = 0;
  int cycles = 0;

  wb_regfile_top #(.ADDR_W(ADDR_W)) wb_regfile_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic add_row(input string name, input logic [5:0] req, input logic [2:0] str,
                         input logic [1:0] ds, input logic [8:0] drs, input logic [15:0] ptr,
                         input logic [15:0] cnt, input logic [31:0] aff,
                         input logic [1:0] dz, input logic [5:0] rds);
    row_t r;
    r.name = name;
    r.req = req;
    r.str = str;
    r.ds = ds;
    r.drs = drs;
    r.rds = rds;
    r.ptr = 32'(ptr);
    r.cnt = 32'(cnt);
    r.aff = aff;
    r.alu = lcg_next();
    r.addr = lcg_next();
    r.nf = (lcg_next() & ~steered_flags) | {21'd0, dz[1], 3'd0, dz[0], 6'd0};
    rows.push_back(r);
  endtask

  // reference model filling the expected columns of the table
  task automatic predict();
    logic [31:0] regs [8];
    eflags_u     fl;
    logic [31:0] first_ptr, cnt_q, step, nptr, ncnt, wd1, m;
    logic [2:0]  d1, d2, d3;
    row_t        r;
    fl.raw = '0;
    first_ptr = '0;
    cnt_q = '0;
    for (int k = 0; k < 8; k++) begin
      regs[k] = '0;
    end
    foreach (rows[i]) begin
      r = rows[i];
      {d1, d2, d3} = r.drs;
      step = (r.ds == size_byte) ? 32'd1 : (r.ds == size_word) ? 32'd2 : 32'd4;
      nptr = fl.named.df ? r.ptr - step : r.ptr + step;
      ncnt = (r.str[0] ? r.cnt : cnt_q) - 32'd1;
      wd1 = r.str[2] ? first_ptr : r.alu;
      r.e_we = r.req[5] & r.req[1];
      r.e_data = wd1;
      r.e_done = r.req[5] & r.str[1] & (fl.named.zf | (ncnt == 32'd0));
      if (r.req[5]) begin
        // later ports overwrite earlier ones
        if (r.req[4]) begin
          if (r.ds == size_byte) begin
            regs[d1][7:0] = wd1[7:0];
          end else if (r.ds == size_word) begin
            regs[d1][15:0] = wd1[15:0];
          end else begin
            regs[d1] = wd1;
          end
        end
        if (r.req[3]) begin
          regs[d2] = nptr;
        end
        if (r.req[2]) begin
          regs[d3] = ncnt;
          cnt_q = ncnt;
        end
        if (r.req[0]) begin
          m = r.aff & defined_flags;
          fl.raw = (fl.raw & ~m) | (r.nf & m);
        end
        if (r.str[2]) begin
          first_ptr = nptr;
        end
      end
      r.e_rd_a = regs[r.rds[5:3]];
      r.e_rd_b = regs[r.rds[2:0]];
      r.e_flags = fl.raw;
      rows[i] = r;
    end
  endtask

  task automatic check(input string tname, input string what,
                       input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s %s expected %h actual %h", tname, what, exp, act);
    end
  endtask

  // live low turns the row into an idle cycle that only reads
  task automatic drive(input row_t r, input logic live);
    wb_v = live & r.req[5];
    {ld_gpr1, ld_gpr2, ld_gpr3, dcache_write, ld_flags} = live ? r.req[4:0] : 5'd0;
    {is_cmps_first, is_cmps_second, is_repne_first} = live ? r.str : 3'd0;
    datasize = r.ds;
    {dr1, dr2, dr3} = r.drs;
    {rd_addr_a, rd_addr_b} = r.rds;
    cmps_pointer = r.ptr;
    count = r.cnt;
    flags_affected = r.aff;
    new_flags = r.nf;
    alu_result = r.alu;
    address = r.addr;
  endtask

  // run length is two cycles per row, reset and a margin
  always @(posedge clk) begin
    cycles++;
    if (cycles > 2 * rows.size() + 16 + 50) begin
      $display("timeout after %0d cycles, the table did not finish", cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial begin
    int   fails;
    row_t r;
    rst = 1'b1;
    // req v,ld1,ld2,ld3,st,ldf  str first,second,repfirst  ds 0/1/2  dz df,zf
    add_row("rst_r01",   6'b000000, 3'b000, 2'd2, 9'o000, 16'h0, 16'h0, 32'h0, 2'b00, 6'o01);
    add_row("rst_r23",   6'b000000, 3'b000, 2'd2, 9'o000, 16'h0, 16'h0, 32'h0, 2'b00, 6'o23);
    add_row("rst_r45",   6'b000000, 3'b000, 2'd2, 9'o000, 16'h0, 16'h0, 32'h0, 2'b00, 6'o45);
    add_row("rst_r67",   6'b000000, 3'b000, 2'd2, 9'o000, 16'h0, 16'h0, 32'h0, 2'b00, 6'o67);
    add_row("gated_wr",  6'b011111, 3'b111, 2'd2, 9'o123, 16'h10, 16'h5, 32'hffffffff, 2'b11, 6'o12);
    add_row("dword_w1",  6'b110000, 3'b000, 2'd2, 9'o100, 16'h0, 16'h0, 32'h0, 2'b00, 6'o10);
    add_row("word_w1",   6'b110000, 3'b000, 2'd1, 9'o100, 16'h0, 16'h0, 32'h0, 2'b00, 6'o13);
    add_row("byte_w1",   6'b110000, 3'b000, 2'd0, 9'o100, 16'h0, 16'h0, 32'h0, 2'b00, 6'o12);
    add_row("byte_w2",   6'b110000, 3'b000, 2'd0, 9'o200, 16'h0, 16'h0, 32'h0, 2'b00, 6'o21);
    add_row("same_reg",  6'b111100, 3'b000, 2'd2, 9'o444, 16'h1000, 16'h0, 32'h0, 2'b00, 6'o41);
    add_row("flags_all", 6'b100001, 3'b000, 2'd2, 9'o000, 16'h0, 16'h0, 32'hffffffff, 2'b00, 6'o00);
    add_row("flags_part", 6'b100001, 3'b000, 2'd2, 9'o000, 16'h0, 16'h0, 32'h000000f0, 2'b00, 6'o00);
    add_row("ptr_up",    6'b101000, 3'b000, 2'd1, 9'o050, 16'h2000, 16'h0, 32'h0, 2'b00, 6'o50);
    add_row("df_set",    6'b100001, 3'b000, 2'd2, 9'o000, 16'h0, 16'h0, 32'h00000400, 2'b10, 6'o00);
    add_row("ptr_down",  6'b101000, 3'b000, 2'd1, 9'o050, 16'h2000, 16'h0, 32'h0, 2'b00, 6'o50);
    add_row("df_clr",    6'b100001, 3'b000, 2'd2, 9'o000, 16'h0, 16'h0, 32'h00000400, 2'b00, 6'o00);
    add_row("cmps_a",    6'b101000, 3'b100, 2'd2, 9'o060, 16'h3000, 16'h0, 32'h0, 2'b00, 6'o60);
    add_row("cmps_b",    6'b110010, 3'b100, 2'd2, 9'o700, 16'h4000, 16'h0, 32'h0, 2'b00, 6'o76);
    add_row("rep_start", 6'b100100, 3'b001, 2'd0, 9'o003, 16'h0, 16'h3, 32'h0, 2'b00, 6'o30);
    add_row("rep_step",  6'b100100, 3'b010, 2'd0, 9'o003, 16'h50, 16'h0, 32'h0, 2'b00, 6'o30);
    add_row("rep_last",  6'b100100, 3'b010, 2'd0, 9'o003, 16'h51, 16'h0, 32'h0, 2'b00, 6'o30);
    add_row("zf_set",    6'b100001, 3'b000, 2'd2, 9'o000, 16'h0, 16'h0, 32'h00000040, 2'b01, 6'o00);
    add_row("rep_zf",    6'b100100, 3'b011, 2'd0, 9'o003, 16'h60, 16'ha, 32'h0, 2'b00, 6'o30);
    add_row("st_dword",  6'b100010, 3'b000, 2'd2, 9'o000, 16'h0, 16'h0, 32'h0, 2'b00, 6'o17);
    add_row("st_byte",   6'b100010, 3'b000, 2'd0, 9'o000, 16'h0, 16'h0, 32'h0, 2'b00, 6'o17);
    add_row("st_gated",  6'b000010, 3'b000, 2'd1, 9'o000, 16'h0, 16'h0, 32'h0, 2'b00, 6'o17);
    predict();
    drive(rows[0], 1'b0);
    repeat (16) @(posedge clk);
    #5;
    rst = 1'b0;
    foreach (rows[i]) begin
      r = rows[i];
      fails = errors;
      // uop cycle with combinational store and termination outputs
      @(posedge clk);
      #5;
      drive(r, 1'b1);
      @(negedge clk);
      check(r.name, "dcache_we", 32'(r.e_we), 32'(dcache_we));
      check(r.name, "repne_done", 32'(r.e_done), 32'(repne_done));
      if (r.e_we) begin
        check(r.name, "dcache_data", r.e_data, dcache_data);
        check(r.name, "dcache_addr", r.addr, dcache_addr);
        check(r.name, "dcache_size", 32'(r.ds), 32'(dcache_size));
      end
      // idle cycle reads back what the uop wrote
      @(posedge clk);
      #5;
      drive(r, 1'b0);
      @(negedge clk);
      check(r.name, "rd_data_a", r.e_rd_a, rd_data_a);
      check(r.name, "rd_data_b", r.e_rd_b, rd_data_b);
      check(r.name, "flags", r.e_flags, flags);
      $display("%-12s %s", r.name, (errors == fails) ? "ok" : "mismatch");
    end
    $display("rows %0d checks %0d errors %0d", rows.size(), checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: dv/wb_assert.sv
// writeback stage assertions
`timescale 1ns/100ps

module wb_assert
  import wb_pkg::*;
(
  input logic        clk,
  input logic        rst,
  input logic        wb_v,
  input logic        ld_flags,
  input logic [31:0] flags_affected,
  input logic [31:0] flags
);

  // flags hold unless a valid uop loads them
  a_flags_hold: assert property (@(posedge clk) disable iff (rst)
    !(wb_v && ld_flags) |=> $stable(flags))
    else $error("flags changed without a valid flags load");

  // a load touches only affected and defined bits
  a_flags_masked: assert property (@(posedge clk) disable iff (rst)
    (wb_v && ld_flags) |=>
      (((flags ^ $past(flags)) & ~($past(flags_affected) & flags_write_mask)) == 32'd0))
    else $error("flags load changed a bit that is not affected or not defined");

  // flags come out of reset cleared
  a_flags_reset: assert property (@(posedge clk) rst |=> (flags == 32'd0))
    else $error("flags not zero after reset");

endmodule

bind writeback_stage wb_assert wb_assert_i (
  .clk            (clk),
  .rst            (rst),
  .wb_v           (wb_v),
  .ld_flags       (ld_flags),
  .flags_affected (flags_affected),
  .flags          (flags)
);

// File: src/cmps_repne_unit.sv
// string compare and repne counter
`timescale 1ns/100ps

module cmps_repne_unit
  import wb_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        v,
  input  logic        is_cmps_first,
  input  logic        is_cmps_second,
  input  logic        is_repne_first,
  input  logic        ld_count,
  input  logic        dir_flag,
  input  logic        zero_flag,
  input  logic [1:0]  datasize,
  input  logic [31:0] pointer,
  input  logic [31:0] count,
  output logic [31:0] next_pointer,
  output logic [31:0] first_pointer,
  output logic [31:0] next_count,
  output logic        repne_done
);

  logic [31:0] step;
  logic [31:0] count_q;
  logic [31:0] count_base;

  // bytes per element
  always_comb begin
    case (datasize)
      size_byte: step = 32'd1;
      size_word: step = 32'd2;
      default:   step = 32'd4;
    endcase
  end

  // DF set walks the string downward
  assign next_pointer = dir_flag ? (pointer - step) : (pointer + step);

  // pointer of the first operand held for the second compare uop
  always_ff @(posedge clk) begin
    if (rst) begin
      first_pointer <= '0;
    end else if (v && is_cmps_first) begin
      first_pointer <= next_pointer;
    end
  end

  // first uop of a repeat takes ECX from the input, later ones the held copy
  assign count_base = is_repne_first ? count : count_q;
  assign next_count = count_base - 32'd1;

  always_ff @(posedge clk) begin
    if (rst) begin
      count_q <= '0;
    end else if (v && ld_count) begin
      count_q <= next_count;
    end
  end

  // stop on a match or when the count runs out
  assign repne_done = v && is_cmps_second && (zero_flag || (next_count == 32'd0));

endmodule

// File: src/gpr_read_port.sv
// register file read port
`timescale 1ns/100ps

module gpr_read_port #(
  parameter int ADDR_W = 3
) (
  input  logic [2**ADDR_W-1:0][31:0] reg_q,
  input  logic [ADDR_W-1:0]          rd_addr_a,
  input  logic [ADDR_W-1:0]          rd_addr_b,
  output logic [31:0]                rd_data_a,
  output logic [31:0]                rd_data_b
);

  localparam int NREG = 2**ADDR_W;

  // two independent selects and no bypass from the write side
  always_comb begin
    rd_data_a = '0;
    rd_data_b = '0;
    for (int i = 0; i < NREG; i++) begin
      if (rd_addr_a == ADDR_W'(i)) begin
        rd_data_a = reg_q[i];
      end
      if (rd_addr_b == ADDR_W'(i)) begin
        rd_data_b = reg_q[i];
      end
    end
  end

endmodule

// File: src/gpr_slice.sv
// general purpose register slice
`timescale 1ns/100ps

module gpr_slice
  import wb_pkg::*;
#(
  parameter int IDX    = 0,
  parameter int ADDR_W = 3
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              we1,
  input  logic              we2,
  input  logic              we3,
  input  logic [ADDR_W-1:0] wa1,
  input  logic [ADDR_W-1:0] wa2,
  input  logic [ADDR_W-1:0] wa3,
  input  logic [31:0]       wd1,
  input  logic [31:0]       wd2,
  input  logic [31:0]       wd3,
  input  logic [1:0]        datasize,
  output logic [31:0]       q
);

  localparam logic [ADDR_W-1:0] MY_ADDR = ADDR_W'(IDX);

  logic        hit1;
  logic        hit2;
  logic        hit3;
  logic [31:0] merged1;

  assign hit1 = we1 && (wa1 == MY_ADDR);
  assign hit2 = we2 && (wa2 == MY_ADDR);
  assign hit3 = we3 && (wa3 == MY_ADDR);

  // port 1 keeps the upper bits on narrow writes
  always_comb begin
    case (datasize)
      size_byte: merged1 = {q[31:8], wd1[7:0]};
      size_word: merged1 = {q[31:16], wd1[15:0]};
      default:   merged1 = wd1;
    endcase
  end

  // port 3 over port 2 over port 1
  always_ff @(posedge clk) begin
    if (rst) begin
      q <= '0;
    end else if (hit3) begin
      q <= wd3;
    end else if (hit2) begin
      q <= wd2;
    end else if (hit1) begin
      q <= merged1;
    end
  end

endmodule

// File: src/wb_pkg.sv
// writeback shared definitions
package wb_pkg;

  // operand size codes from decode
  localparam logic [1:0] size_byte  = 2'd0;
  localparam logic [1:0] size_word  = 2'd1;
  localparam logic [1:0] size_dword = 2'd2;

  // architectural flag positions in the eflags word
  localparam int unsigned cf_bit = 0;
  localparam int unsigned pf_bit = 2;
  localparam int unsigned af_bit = 4;
  localparam int unsigned zf_bit = 6;
  localparam int unsigned sf_bit = 7;
  localparam int unsigned df_bit = 10;
  localparam int unsigned of_bit = 11;

  // only these bits can ever be loaded
  localparam logic [31:0] flags_write_mask = (32'd1 << cf_bit) |
                                             (32'd1 << pf_bit) |
                                             (32'd1 << af_bit) |
                                             (32'd1 << zf_bit) |
                                             (32'd1 << sf_bit) |
                                             (32'd1 << df_bit) |
                                             (32'd1 << of_bit);

  // flags word seen as one raw word or as named bits
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [19:0] rsvd_hi;
      logic        of;
      logic        df;
      logic [1:0]  rsvd_9_8;
      logic        sf;
      logic        zf;
      logic        rsvd_5;
      logic        af;
      logic        rsvd_3;
      logic        pf;
      logic        rsvd_1;
      logic        cf;
    } named;
  } eflags_u;

endpackage

// File: src/wb_regfile_top.sv
// writeback and register file top
`timescale 1ns/100ps

module wb_regfile_top #(
  parameter int ADDR_W = 3
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              wb_v,
  input  logic              ld_gpr1,
  input  logic              ld_gpr2,
  input  logic              ld_gpr3,
  input  logic              dcache_write,
  input  logic              ld_flags,
  input  logic [31:0]       flags_affected,
  input  logic [31:0]       new_flags,
  input  logic              is_cmps_first,
  input  logic              is_cmps_second,
  input  logic              is_repne_first,
  input  logic [1:0]        datasize,
  input  logic [31:0]       alu_result,
  input  logic [31:0]       cmps_pointer,
  input  logic [31:0]       count,
  input  logic [31:0]       address,
  input  logic [ADDR_W-1:0] dr1,
  input  logic [ADDR_W-1:0] dr2,
  input  logic [ADDR_W-1:0] dr3,
  input  logic [ADDR_W-1:0] rd_addr_a,
  input  logic [ADDR_W-1:0] rd_addr_b,
  output logic [31:0]       rd_data_a,
  output logic [31:0]       rd_data_b,
  output logic [31:0]       flags,
  output logic              dcache_we,
  output logic [31:0]       dcache_data,
  output logic [31:0]       dcache_addr,
  output logic [1:0]        dcache_size,
  output logic              repne_done
);

  localparam int NREG = 2**ADDR_W;

  logic                   we1;
  logic                   we2;
  logic                   we3;
  logic [ADDR_W-1:0]      wa1;
  logic [ADDR_W-1:0]      wa2;
  logic [ADDR_W-1:0]      wa3;
  logic [31:0]            wd1;
  logic [31:0]            wd2;
  logic [31:0]            wd3;
  logic [NREG-1:0][31:0]  reg_q;

  writeback_stage #(
    .ADDR_W(ADDR_W)
  ) writeback_stage_i (
    .clk            (clk),
    .rst            (rst),
    .wb_v           (wb_v),
    .ld_gpr1        (ld_gpr1),
    .ld_gpr2        (ld_gpr2),
    .ld_gpr3        (ld_gpr3),
    .dcache_write   (dcache_write),
    .ld_flags       (ld_flags),
    .flags_affected (flags_affected),
    .new_flags      (new_flags),
    .is_cmps_first  (is_cmps_first),
    .is_cmps_second (is_cmps_second),
    .is_repne_first (is_repne_first),
    .datasize       (datasize),
    .alu_result     (alu_result),
    .cmps_pointer   (cmps_pointer),
    .count          (count),
    .address        (address),
    .dr1            (dr1),
    .dr2            (dr2),
    .dr3            (dr3),
    .we1            (we1),
    .we2            (we2),
    .we3            (we3),
    .wa1            (wa1),
    .wa2            (wa2),
    .wa3            (wa3),
    .wd1            (wd1),
    .wd2            (wd2),
    .wd3            (wd3),
    .flags          (flags),
    .dcache_we      (dcache_we),
    .dcache_data    (dcache_data),
    .dcache_addr    (dcache_addr),
    .dcache_size    (dcache_size),
    .repne_done     (repne_done)
  );

  // one slice per architectural register
  for (genvar i = 0; i < NREG; i++) begin : g_gpr
    gpr_slice #(
      .IDX    (i),
      .ADDR_W (ADDR_W)
    ) gpr_slice_i (
      .clk      (clk),
      .rst      (rst),
      .we1      (we1),
      .we2      (we2),
      .we3      (we3),
      .wa1      (wa1),
      .wa2      (wa2),
      .wa3      (wa3),
      .wd1      (wd1),
      .wd2      (wd2),
      .wd3      (wd3),
      .datasize (datasize),
      .q        (reg_q[i])
    );
  end

  gpr_read_port #(
    .ADDR_W(ADDR_W)
  ) gpr_read_port_i (
    .reg_q     (reg_q),
    .rd_addr_a (rd_addr_a),
    .rd_addr_b (rd_addr_b),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b)
  );

endmodule

// File: src/writeback_stage.sv
// writeback stage
`timescale 1ns/100ps

module writeback_stage
  import wb_pkg::*;
#(
  parameter int ADDR_W = 3
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              wb_v,
  input  logic              ld_gpr1,
  input  logic              ld_gpr2,
  input  logic              ld_gpr3,
  input  logic              dcache_write,
  input  logic              ld_flags,
  input  logic [31:0]       flags_affected,
  input  logic [31:0]       new_flags,
  input  logic              is_cmps_first,
  input  logic              is_cmps_second,
  input  logic              is_repne_first,
  input  logic [1:0]        datasize,
  input  logic [31:0]       alu_result,
  input  logic [31:0]       cmps_pointer,
  input  logic [31:0]       count,
  input  logic [31:0]       address,
  input  logic [ADDR_W-1:0] dr1,
  input  logic [ADDR_W-1:0] dr2,
  input  logic [ADDR_W-1:0] dr3,
  output logic              we1,
  output logic              we2,
  output logic              we3,
  output logic [ADDR_W-1:0] wa1,
  output logic [ADDR_W-1:0] wa2,
  output logic [ADDR_W-1:0] wa3,
  output logic [31:0]       wd1,
  output logic [31:0]       wd2,
  output logic [31:0]       wd3,
  output logic [31:0]       flags,
  output logic              dcache_we,
  output logic [31:0]       dcache_data,
  output logic [31:0]       dcache_addr,
  output logic [1:0]        dcache_size,
  output logic              repne_done
);

  logic [31:0] next_pointer;
  logic [31:0] first_pointer;
  logic [31:0] next_count;
  logic [31:0] flag_mask;
  // architectural flags read both as a word and by name
  eflags_u     flags_q;

  cmps_repne_unit cmps_repne_unit_i (
    .clk            (clk),
    .rst            (rst),
    .v              (wb_v),
    .is_cmps_first  (is_cmps_first),
    .is_cmps_second (is_cmps_second),
    .is_repne_first (is_repne_first),
    .ld_count       (ld_gpr3),
    .dir_flag       (flags_q.named.df),
    .zero_flag      (flags_q.named.zf),
    .datasize       (datasize),
    .pointer        (cmps_pointer),
    .count          (count),
    .next_pointer   (next_pointer),
    .first_pointer  (first_pointer),
    .next_count     (next_count),
    .repne_done     (repne_done)
  );

  assign we1 = wb_v && ld_gpr1;
  assign we2 = wb_v && ld_gpr2;
  assign we3 = wb_v && ld_gpr3;
  assign wa1 = dr1;
  assign wa2 = dr2;
  assign wa3 = dr3;
  assign wd1 = is_cmps_first ? first_pointer : alu_result;
  assign wd2 = next_pointer;
  assign wd3 = next_count;

  assign dcache_we   = wb_v && dcache_write;
  assign dcache_data = wd1;
  assign dcache_addr = address;
  assign dcache_size = datasize;

  assign flag_mask = flags_affected & flags_write_mask;
  assign flags     = flags_q.raw;

  always_ff @(posedge clk) begin
    if (rst) begin
      flags_q.raw <= '0;
    end else if (wb_v && ld_flags) begin
      flags_q.raw <= (flags_q.raw & ~flag_mask) | (new_flags & flag_mask);
    end
  end

endmodule

// File: tb.f
src/wb_pkg.sv
src/cmps_repne_unit.sv
src/writeback_stage.sv
src/gpr_slice.sv
src/gpr_read_port.sv
src/wb_regfile_top.sv
dv/wb_assert.sv
dv/tb_wb.sv
